/* common/SmTypesPkg.sv */
// Sensor manager data widths and the vector types built on them
package SmTypesPkg;

        // --------------------
        // Field widths
        // --------------------

        // Program memory holds 1024 words of 18 bits
        localparam int AddrWidth = 10;
        localparam int WordWidth = 18;

        // Words written back to memory are 9 bits wide
        localparam int WriteWidth = 9;

        // Data field of an instruction word
        localparam int DataWidth = 10;

        // Delta timestamp and one stored byte of it
        localparam int DeltaWidth = 16;
        localparam int ByteWidth = 8;

        // Wide enough for a scaled wait of 511 * 16 + 15
        localparam int WaitWidth = 13;

        // One interrupt input and one event flag per sensor
        localparam int NumSensors = 4;

        // --------------------
        // Vector types
        // --------------------
        typedef logic [AddrWidth-1:0]  SmAddr_t;
        typedef logic [WordWidth-1:0]  SmWord_t;
        typedef logic [WriteWidth-1:0] SmWriteData_t;
        typedef logic [DataWidth-1:0]  SmData_t;
        typedef logic [DeltaWidth-1:0] TsDelta_t;
        typedef logic [ByteWidth-1:0]  TsByte_t;
        typedef logic [NumSensors-1:0] SensorFlags_t;
        typedef logic [WaitWidth-1:0]  WaitCount_t;

endpackage

/* common/SmRegMapPkg.sv */
// Sensor manager register map with address spaces, register indices and field positions
package SmRegMapPkg;

        // The register address in bits 7..0 splits into a space and an index
        localparam int SpaceWidth = 5;
        localparam int IndexWidth = 3;

        typedef logic [SpaceWidth-1:0]            RegSpace_t;
        typedef logic [IndexWidth-1:0]            RegIndex_t;
        typedef logic [SpaceWidth+IndexWidth-1:0] RegAddr_t;

        // --------------------
        // Address spaces
        // --------------------
        localparam RegSpace_t SpaceSequencer = 5'd0;
        localparam RegSpace_t SpaceTimeStamp = 5'd2;

        // Registers of the sequencer itself
        localparam RegIndex_t RegControl = 3'd0;
        localparam RegIndex_t RegReceive = 3'd1;
        localparam RegIndex_t RegRunTime = 3'd2;
        localparam RegIndex_t RegWait    = 3'd4;
        localparam RegIndex_t RegJump    = 3'd7;

        // Registers of the timestamp unit
        localparam RegIndex_t TsSensor0    = 3'd0;
        localparam RegIndex_t TsSensor1    = 3'd1;
        localparam RegIndex_t TsSensor2    = 3'd2;
        localparam RegIndex_t TsSensor3    = 3'd3;
        localparam RegIndex_t TsGenericLsb = 3'd4;
        localparam RegIndex_t TsGenericMsb = 3'd5;
        localparam RegIndex_t TsIntEvent   = 3'd6;

        // --------------------
        // Instruction field positions
        // --------------------

        // The data field starts right above the register address
        localparam int DataLsb = 8;

        // When this word bit is set one wait unit lasts 16 cycles
        localparam int WaitScaleBit = 17;

endpackage

/* sequencer/SmWaitTimer.sv */
// Wait timer counting a programmed delay in single or sixteen-cycle units
module SmWaitTimer
        import SmTypesPkg::*, SmRegMapPkg::*;
(
        input  logic    ClockIn,
        input  logic    ResetIn,
        input  logic    WaitLoad_i,
        input  SmData_t WaitData_i,
        output logic    WaitBusy_o
);

        // Position of the scale flag inside the data field
        localparam int ScaleBit = WaitScaleBit - DataLsb;

        WaitCount_t loadValue;
        WaitCount_t count;
        logic       active;

        // A scaled count N becomes N * 16 + 15 so the period is 16 * (N + 1)
        always_comb
        begin
                if (WaitData_i[ScaleBit])
                        loadValue = {WaitData_i[ScaleBit-1:0], 4'hF};
                else
                        loadValue = WaitCount_t'(WaitData_i[ScaleBit-1:0]);
        end

        // The counter stays active until it has stepped down to zero
        always_ff @(posedge ClockIn or posedge ResetIn)
        begin
                if (ResetIn)
                begin
                        count  <= '0;
                        active <= 1'b0;
                end
                else if (WaitLoad_i)
                begin
                        count  <= loadValue;
                        active <= (loadValue != '0);
                end
                else if (active)
                begin
                        count  <= count - WaitCount_t'(1);
                        active <= (count != WaitCount_t'(1));
                end
        end

        // The load cycle counts as the first busy cycle
        assign WaitBusy_o = WaitLoad_i | active;

endmodule

/* sequencer/SmSequencer.sv */
// Sequencer that fetches program words, decodes them and runs register and memory accesses
module SmSequencer
        import SmTypesPkg::*, SmRegMapPkg::*;
#(
        parameter int SyncStages = 2
)
(
        input  logic         ClockIn,
        input  logic         ResetIn,
        input  logic         Start_i,
        input  SmWord_t      MemReadData_i,
        input  SmWriteData_t TsReadByte_i,
        output SmAddr_t      MemReadAddress_o,
        output logic         MemReadEnable_o,
        output SmAddr_t      MemWriteAddress_o,
        output logic         MemWriteEnable_o,
        output SmWriteData_t MemWriteData_o,
        output logic         TsAccess_o,
        output RegIndex_t    TsIndex_o,
        output SmData_t      TsData_o,
        output logic         Busy_o
);

        typedef enum logic [2:0] {
                StateIdle,
                StateFetch,
                StateExecute,
                StateStore,
                StateWait
        } SeqState_t;

        // The extra stage past the synchronizer keeps the old level for toggle detection
        logic [SyncStages:0] startSync;
        logic                startStrobe;
        logic                runFlag;
        SeqState_t           state;
        SeqState_t           nextState;
        SmAddr_t             instrPtr;
        SmAddr_t             receiveAddr;
        SmAddr_t             runTimeAddr;
        RegAddr_t            regAddr;
        RegSpace_t           regSpace;
        RegIndex_t           regIndex;
        SmData_t             instrData;
        logic                execSeq;
        logic                execTs;
        logic                waitLoad;
        logic                waitBusy;

        // --------------------
        // Instruction decode
        // --------------------

        // Read data is only meaningful in Execute, one cycle after the Fetch read
        assign regAddr   = MemReadData_i[DataLsb-1:0];
        assign regSpace  = regAddr[IndexWidth +: SpaceWidth];
        assign regIndex  = regAddr[IndexWidth-1:0];
        assign instrData = MemReadData_i[DataLsb +: DataWidth];
        assign execSeq   = (state == StateExecute) && (regSpace == SpaceSequencer);
        assign execTs    = (state == StateExecute) && (regSpace == SpaceTimeStamp);
        assign waitLoad  = execSeq && (regIndex == RegWait);

        // Either toggle direction on the start input counts as a start
        assign startStrobe = startSync[SyncStages-1] ^ startSync[SyncStages];

        always_ff @(posedge ClockIn or posedge ResetIn)
        begin
                if (ResetIn)
                begin
                        startSync   <= '0;
                        runFlag     <= 1'b0;
                        state       <= StateIdle;
                        instrPtr    <= '0;
                        receiveAddr <= '0;
                        runTimeAddr <= '0;
                end
                else
                begin
                        startSync <= {startSync[SyncStages-1:0], Start_i};
                        state     <= nextState;

                        // A start wins over a stop that lands in the same cycle
                        if (startStrobe)
                                runFlag <= 1'b1;
                        else if (execSeq && (regIndex == RegControl))
                                runFlag <= instrData[0];

                        // Each run begins at the run-time start address
                        if ((state == StateIdle) && runFlag)
                                instrPtr <= runTimeAddr;
                        else if (execSeq && (regIndex == RegJump))
                                instrPtr <= instrData;
                        else if (state == StateExecute)
                                instrPtr <= instrPtr + SmAddr_t'(1);

                        // Timestamp reads carry their own memory destination
                        if (execTs || (execSeq && (regIndex == RegReceive)))
                                receiveAddr <= instrData;

                        if (execSeq && (regIndex == RegRunTime))
                                runTimeAddr <= instrData;
                end
        end

        // --------------------
        // Next state
        // --------------------
        always_comb
        begin
                nextState = state;
                case (state)
                        StateIdle:
                                if (runFlag)
                                        nextState = StateFetch;
                        StateFetch:
                                nextState = StateExecute;
                        StateExecute:
                                if (execTs)
                                        nextState = StateStore;
                                else if (waitLoad)
                                        nextState = StateWait;
                                else if (execSeq && (regIndex == RegControl) && !instrData[0])
                                        nextState = StateIdle;
                                else
                                        nextState = StateFetch;
                        StateStore:
                                nextState = StateFetch;
                        StateWait:
                                if (!waitBusy)
                                        nextState = StateFetch;
                        default:
                                nextState = StateIdle;
                endcase
        end

        SmWaitTimer waitTimerInst (
                .ClockIn     (ClockIn),
                .ResetIn     (ResetIn),
                .WaitLoad_i  (waitLoad),
                .WaitData_i  (instrData),
                .WaitBusy_o  (waitBusy)
        );

        // Memory ports and the timestamp access strobe
        assign MemReadAddress_o  = instrPtr;
        assign MemReadEnable_o   = (state == StateFetch);
        assign MemWriteAddress_o = receiveAddr;
        assign MemWriteEnable_o  = (state == StateStore);
        assign MemWriteData_o    = TsReadByte_i;
        assign TsAccess_o        = execTs;
        assign TsIndex_o         = regIndex;
        assign TsData_o          = instrData;

        // Busy covers the tail of a program after the run flag drops
        assign Busy_o = runFlag | (state != StateIdle);

endmodule

/* timestamp/TimeStampUnit.sv */
// Timestamp unit capturing delta timestamps, per-sensor interrupt bytes and event flags
module TimeStampUnit
        import SmTypesPkg::*, SmRegMapPkg::*;
#(
        parameter int SyncStages = 2
)
(
        input  logic         ClockIn,
        input  logic         ResetIn,
        input  TsDelta_t     TimeStampDelta_i,
        input  logic         TimeStampToggle_i,
        input  SensorFlags_t SensorInterrupt_i,
        input  logic         TsAccess_i,
        input  RegIndex_t    TsIndex_i,
        input  SmData_t      TsData_i,
        output SensorFlags_t SensorEvent_o,
        output SmWriteData_t TsReadByte_o
);

        // Bit 0 carries the timestamp toggle and the upper bits the sensor interrupts
        logic [NumSensors:0] syncChain [0:SyncStages];
        logic                toggleEdge;
        SensorFlags_t        intRise;
        SensorFlags_t        eventClear;
        SensorFlags_t        eventFlags;
        TsDelta_t            capturedDelta;
        TsDelta_t            snapshot;
        TsByte_t             sensorByte [NumSensors];

        // --------------------
        // Input synchronizers
        // --------------------
        always_ff @(posedge ClockIn or posedge ResetIn)
        begin
                if (ResetIn)
                begin
                        for (int k = 0; k <= SyncStages; k++)
                                syncChain[k] <= '0;
                end
                else
                begin
                        syncChain[0] <= {SensorInterrupt_i, TimeStampToggle_i};
                        for (int k = 1; k <= SyncStages; k++)
                                syncChain[k] <= syncChain[k-1];
                end
        end

        // The last stage holds the previous level for edge detection
        assign toggleEdge = syncChain[SyncStages-1][0] ^ syncChain[SyncStages][0];
        assign intRise    = syncChain[SyncStages-1][NumSensors:1]
                          & ~syncChain[SyncStages][NumSensors:1];

        // An event read clears only the flags picked by its mask bits
        assign eventClear = (TsAccess_i && (TsIndex_i == TsIntEvent))
                          ? TsData_i[NumSensors-1:0] : '0;

        // Clearing beats a rising edge seen in the same cycle
        always_ff @(posedge ClockIn or posedge ResetIn)
        begin
                if (ResetIn)
                        eventFlags <= '0;
                else
                        eventFlags <= (eventFlags | intRise) & ~eventClear;
        end

        assign SensorEvent_o = eventFlags;

        // --------------------
        // Capture and readback
        // --------------------
        always_ff @(posedge ClockIn)
        begin
                if (toggleEdge)
                        capturedDelta <= TimeStampDelta_i;

                // Each sensor keeps the low byte current at its interrupt edge
                for (int i = 0; i < NumSensors; i++)
                begin
                        if (intRise[i])
                                sensorByte[i] <= capturedDelta[ByteWidth-1:0];
                end

                // The LSB read freezes the whole value so the MSB read matches it
                if (TsAccess_i)
                begin
                        case (TsIndex_i)
                                TsSensor0, TsSensor1, TsSensor2, TsSensor3:
                                        TsReadByte_o <= SmWriteData_t'(sensorByte[TsIndex_i[1:0]]);
                                TsGenericLsb:
                                begin
                                        snapshot     <= capturedDelta;
                                        TsReadByte_o <= SmWriteData_t'(capturedDelta[ByteWidth-1:0]);
                                end
                                TsGenericMsb:
                                        TsReadByte_o <= SmWriteData_t'(snapshot[DeltaWidth-1:ByteWidth]);
                                TsIntEvent:
                                        TsReadByte_o <= SmWriteData_t'(eventFlags);
                                default:
                                        TsReadByte_o <= '0;
                        endcase
                end
        end

endmodule

/* hw/SensorManager.sv */
// Sensor manager top level joining the sequencer, the timestamp unit and the memory ports
module SensorManager
        import SmTypesPkg::*, SmRegMapPkg::*;
#(
        parameter int SyncStages = 2
)
(
        input  logic         ClockIn,
        input  logic         ResetIn,
        input  logic         Start_i,
        input  TsDelta_t     TimeStampDelta_i,
        input  logic         TimeStampToggle_i,
        input  SensorFlags_t SensorInterrupt_i,
        input  SmWord_t      MemReadData_i,
        output SensorFlags_t SensorEvent_o,
        output logic         Busy_o,
        output SmAddr_t      MemReadAddress_o,
        output logic         MemReadEnable_o,
        output SmAddr_t      MemWriteAddress_o,
        output logic         MemWriteEnable_o,
        output SmWriteData_t MemWriteData_o
);

        // Register access from the sequencer into the timestamp unit
        logic         tsAccess;
        RegIndex_t    tsIndex;
        SmData_t      tsData;

        // Byte returned by the timestamp unit one cycle after the access
        SmWriteData_t tsReadByte;

        // --------------------
        // Program sequencer
        // --------------------
        SmSequencer #(
                .SyncStages        (SyncStages)
        ) sequencerInst (
                .ClockIn           (ClockIn),
                .ResetIn           (ResetIn),
                .Start_i           (Start_i),
                .MemReadData_i     (MemReadData_i),
                .TsReadByte_i      (tsReadByte),
                .MemReadAddress_o  (MemReadAddress_o),
                .MemReadEnable_o   (MemReadEnable_o),
                .MemWriteAddress_o (MemWriteAddress_o),
                .MemWriteEnable_o  (MemWriteEnable_o),
                .MemWriteData_o    (MemWriteData_o),
                .TsAccess_o        (tsAccess),
                .TsIndex_o         (tsIndex),
                .TsData_o          (tsData),
                .Busy_o            (Busy_o)
        );

        // --------------------
        // Timestamp and interrupt events
        // --------------------
        TimeStampUnit #(
                .SyncStages        (SyncStages)
        ) timeStampInst (
                .ClockIn           (ClockIn),
                .ResetIn           (ResetIn),
                .TimeStampDelta_i  (TimeStampDelta_i),
                .TimeStampToggle_i (TimeStampToggle_i),
                .SensorInterrupt_i (SensorInterrupt_i),
                .TsAccess_i        (tsAccess),
                .TsIndex_i         (tsIndex),
                .TsData_i          (tsData),
                .SensorEvent_o     (SensorEvent_o),
                .TsReadByte_o      (tsReadByte)
        );

endmodule

/* bench/SmTraceChecks.svh */
// Typed compare tasks and trace line helpers for the sensor manager testbench
`ifndef SM_TRACE_CHECKS_SVH
`define SM_TRACE_CHECKS_SVH

        // Comment lines start with # and blank lines carry no command
        function automatic bit isDataLine(string line);
                byte first;
                if (line.len() == 0)
                        return 1'b0;
                first = line.getc(0);
                return (first != "#") && (first != "\n") && (first != "\r") && (first != " ");
        endfunction

        task automatic compareAddr(string name, SmAddr_t expected, SmAddr_t actual);
                if (expected !== actual)
                begin
                        $display("Mismatch at %0t ns: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        stopRun();
                end
        endtask

        task automatic compareWriteData(string name, SmWriteData_t expected, SmWriteData_t actual);
                if (expected !== actual)
                begin
                        $display("Mismatch at %0t ns: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        stopRun();
                end
        endtask

        task automatic compareFlags(string name, SensorFlags_t expected, SensorFlags_t actual);
                if (expected !== actual)
                begin
                        $display("Mismatch at %0t ns: %s expected %b, got %b",
                                 $time, name, expected, actual);
                        stopRun();
                end
        endtask

        // Single control levels such as busy and the memory enables
        task automatic compareLevel(string name, logic expected, logic actual);
                if (expected !== actual)
                begin
                        $display("Mismatch at %0t ns: %s expected %b, got %b",
                                 $time, name, expected, actual);
                        stopRun();
                end
        endtask

`endif

/* bench/SensorManagerTb.sv */
// Testbench that runs the sensor manager through the program and stimulus trace
module SensorManagerTb
        import SmTypesPkg::*;
();

        timeunit 1ns;
        timeprecision 10ps;

        localparam int SyncStages = 2;

        // Enough cycles for any synchronized input to settle inside the DUT
        localparam int SettleCycles = SyncStages + 2;

        logic         ClockIn;
        logic         ResetIn;
        logic         startToggle;
        TsDelta_t     timeStampDelta;
        logic         timeStampToggle;
        SensorFlags_t sensorInterrupt;
        SmWord_t      memReadData = '0;
        SensorFlags_t sensorEvent;
        logic         busy;
        SmAddr_t      memReadAddress;
        logic         memReadEnable;
        SmAddr_t      memWriteAddress;
        logic         memWriteEnable;
        SmWriteData_t memWriteData;

        // Program memory model and the memory writes seen so far
        SmWord_t      mem [1024];
        logic         readPending = 1'b0;
        SmAddr_t      readAddr = '0;
        SmAddr_t      seenAddr [$];
        SmWriteData_t seenData [$];
        int           seenCycle [$];
        int           consumed = 0;
        string        traceLines [$];
        int           cycleCount = 0;
        int           cycleLimit = 16 * 1024;

        task automatic stopRun();
                $display("FAIL: see errors above");
                $fatal(1);
        endtask

        `include "SmTraceChecks.svh"

        SensorManager #(
                .SyncStages        (SyncStages)
        ) UUT (
                .ClockIn           (ClockIn),
                .ResetIn           (ResetIn),
                .Start_i           (startToggle),
                .TimeStampDelta_i  (timeStampDelta),
                .TimeStampToggle_i (timeStampToggle),
                .SensorInterrupt_i (sensorInterrupt),
                .MemReadData_i     (memReadData),
                .SensorEvent_o     (sensorEvent),
                .Busy_o            (busy),
                .MemReadAddress_o  (memReadAddress),
                .MemReadEnable_o   (memReadEnable),
                .MemWriteAddress_o (memWriteAddress),
                .MemWriteEnable_o  (memWriteEnable),
                .MemWriteData_o    (memWriteData)
        );

        initial
        begin
                ClockIn = 1'b0;
                forever
                        #10 ClockIn = ~ClockIn;
        end

        // --------------------
        // Memory model and write monitor
        // --------------------

        // A read enabled in one cycle returns its word in the next one
        always @(negedge ClockIn)
        begin
                if (readPending)
                        memReadData <= mem[readAddr];
                readPending <= memReadEnable;
                readAddr    <= memReadAddress;
                if (memWriteEnable)
                begin
                        seenAddr.push_back(memWriteAddress);
                        seenData.push_back(memWriteData);
                        seenCycle.push_back(cycleCount);
                end
        end

        always @(posedge ClockIn)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit)
                begin
                        $display("Error: the run did not finish within %0d cycles", cycleLimit);
                        stopRun();
                end
        end

        // --------------------
        // Trace commands
        // --------------------
        task automatic setTimeStamp(TsDelta_t value);
                timeStampDelta = value;
                @(negedge ClockIn);
                timeStampToggle = ~timeStampToggle;
                repeat (SettleCycles) @(negedge ClockIn);
        endtask

        task automatic pulseInterrupts(SensorFlags_t mask);
                sensorInterrupt = mask;
                repeat (SettleCycles) @(negedge ClockIn);
                sensorInterrupt = '0;
                repeat (SettleCycles) @(negedge ClockIn);
        endtask

        // Toggles start and waits for the program to raise and then drop busy
        task automatic runProgram();
                if (seenAddr.size() != consumed)
                begin
                        $display("Error: %0d memory writes appeared that the trace does not expect",
                                 seenAddr.size() - consumed);
                        stopRun();
                end
                else
                begin
                        startToggle = ~startToggle;
                        @(negedge ClockIn);
                        while (!busy)
                                @(negedge ClockIn);
                        while (busy)
                                @(negedge ClockIn);
                end
        endtask

        // Observed writes are checked strictly in the order they happened
        task automatic expectWrite(SmAddr_t addr, SmWriteData_t data);
                if (consumed >= seenAddr.size())
                begin
                        $display("Error: expected a write of %h to address %h, but none appeared",
                                 data, addr);
                        stopRun();
                end
                else
                begin
                        compareAddr("MemWriteAddress_o", addr, seenAddr[consumed]);
                        compareWriteData("MemWriteData_o", data, seenData[consumed]);
                        consumed++;
                end
        endtask

        task automatic checkGap(int minCycles);
                if (consumed < 2)
                begin
                        $display("Error: a write gap check needs two checked writes before it");
                        stopRun();
                end
                else if (seenCycle[consumed-1] - seenCycle[consumed-2] < minCycles)
                begin
                        $display("Error: only %0d cycles between the last two writes, %0d expected",
                                 seenCycle[consumed-1] - seenCycle[consumed-2], minCycles);
                        stopRun();
                end
        endtask

        initial
        begin
                int    fd;
                int    code;
                int    fieldA;
                int    fieldB;
                byte   cmd;
                string line;

                ResetIn         = 1'b1;
                startToggle     = 1'b0;
                timeStampDelta  = '0;
                timeStampToggle = 1'b0;
                sensorInterrupt = '0;

                // Unprogrammed words decode as a control write of zero and stop a run
                foreach (mem[k])
                        mem[k] = '0;

                fd = $fopen("bench/sm_trace.txt", "r");
                if (fd == 0)
                begin
                        $display("Error: the trace file bench/sm_trace.txt could not be opened");
                        stopRun();
                end
                while (!$feof(fd))
                begin
                        code = $fgets(line, fd);
                        if ((code > 0) && isDataLine(line))
                                traceLines.push_back(line);
                end
                $fclose(fd);
                cycleLimit = 200 * traceLines.size() + 16 * 1024;

                repeat (3) @(negedge ClockIn);
                ResetIn = 1'b0;
                compareLevel("Busy_o", 1'b0, busy);
                compareLevel("MemWriteEnable_o", 1'b0, memWriteEnable);
                compareLevel("MemReadEnable_o", 1'b0, memReadEnable);
                compareFlags("SensorEvent_o", '0, sensorEvent);

                foreach (traceLines[i])
                begin
                        cmd  = traceLines[i].getc(0);
                        code = $sscanf(traceLines[i].substr(1, traceLines[i].len() - 1),
                                       "%h %h", fieldA, fieldB);
                        case (cmd)
                                "P": mem[SmAddr_t'(fieldA)] = SmWord_t'(fieldB);
                                "T": setTimeStamp(TsDelta_t'(fieldA));
                                "I": pulseInterrupts(SensorFlags_t'(fieldA));
                                "S": runProgram();
                                "W": expectWrite(SmAddr_t'(fieldA), SmWriteData_t'(fieldB));
                                "F": compareFlags("SensorEvent_o", SensorFlags_t'(fieldA), sensorEvent);
                                "D": checkGap(fieldA);
                                default:
                                begin
                                        $display("Error: trace line %0d holds an unknown command", i);
                                        stopRun();
                                end
                        endcase
                end

                repeat (SettleCycles) @(negedge ClockIn);
                if (seenAddr.size() != consumed)
                begin
                        $display("Error: %0d memory writes appeared that the trace does not expect",
                                 seenAddr.size() - consumed);
                        stopRun();
                end
                else
                begin
                        $display("PASS: all tests");
                        $finish;
                end
        end

endmodule

/* bench/sm_trace.txt */
# Command letter, then hex fields: P addr word, T delta, I mask, S (start and wait)
# W addr data (next memory write), F flags (SensorEvent_o), D mincycles (gap of last two writes)
F 0
T 1234
I 1
T 5678
I 4
T 9abc
F 5
P 000 20010
P 001 20112
P 002 20416
P 003 20214
P 004 01002
P 005 00000
P 006 20515
S
W 200 034
W 201 078
W 204 005
W 202 0bc
F 1
P 010 20315
P 011 01307
P 012 20714
P 013 20615
P 014 20104
P 015 20814
P 016 00000
P 017 20914
T 1357
S
W 203 09a
W 206 09a
W 208 057
D 20
F 1

/* compile.f */
common/SmTypesPkg.sv
common/SmRegMapPkg.sv
sequencer/SmWaitTimer.sv
sequencer/SmSequencer.sv
timestamp/TimeStampUnit.sv
hw/SensorManager.sv
+incdir+bench
bench/SensorManagerTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -j 0 \
        --top-module SensorManagerTb -f compile.f -o SensorManagerSim
./obj_dir/SensorManagerSim | tee sim.log
if grep -q "PASS: all tests" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi
